/* stile_config.svh */
// Super-tile sizing macros
`ifndef STILE_CONFIG_SVH
`define STILE_CONFIG_SVH

// Tile chain
`define STILE_TILES      4    // Tiles in the cascade
`define STILE_TILE_W     2    // Bits of a tile index

// Buffers
`define STILE_DEPTH      64   // Entries per weight, activation and result buffer
`define STILE_ADDR_W     6    // Entry address width

// Datapath widths
`define STILE_WEIGHT_W   8
`define STILE_ACT_W      8
`define STILE_PSUM_W     32   // Partial sum, wraps on overflow

// Wishbone slave
`define STILE_WB_ADDR_W  10   // Word address
`define STILE_WB_DATA_W  32
`define STILE_ACK_DELAY  2    // Edges from strobe to ack

// Bus address map, region | tile | entry
`define STILE_REGION_W   2
`define STILE_REGION_LSB 8
`define STILE_TILE_LSB   6

`endif

/* stile_types_pkg.sv */
// Datapath payload types
`include "stile_config.svh"

package stile_types_pkg;

  // Signed weight as held in a tile
  typedef logic signed [`STILE_WEIGHT_W-1:0] weight_t;

  // Activations carry no sign
  typedef logic [`STILE_ACT_W-1:0] act_t;

  // Cascade partial sum
  // bias plus all tile products, modulo 2^32
  typedef logic signed [`STILE_PSUM_W-1:0] psum_t;

  // Entry address, shared by every buffer in the design
  typedef logic [`STILE_ADDR_W-1:0] buf_addr_t;

endpackage

/* stile_bus_pkg.sv */
// Wishbone address map
`include "stile_config.svh"

package stile_bus_pkg;

  typedef logic [`STILE_WB_ADDR_W-1:0] wb_adr_t;   // Bus word address
  typedef logic [`STILE_TILE_W-1:0]    tile_idx_t; // Tile field of an address
  typedef logic [`STILE_ADDR_W-1:0]    ctrl_off_t; // Register offset in CTRL

  // Top address bits select the region
  typedef enum logic [`STILE_REGION_W-1:0] {
    REGION_WEIGHT = 2'd0,  // Write only, per tile
    REGION_ACT    = 2'd1,  // Write only, per tile
    REGION_CTRL   = 2'd2,
    REGION_RESULT = 2'd3   // Read only
  } region_e;

  // Control registers
  localparam ctrl_off_t CTRL_START  = 6'd0;  // Write run length, 1 to 64
  localparam ctrl_off_t CTRL_BIAS   = 6'd1;  // Bias added at tile 0
  localparam ctrl_off_t CTRL_STATUS = 6'd2;  // Read only

  localparam int STATUS_BUSY_BIT = 0;

  function automatic region_e region_of(input wb_adr_t adr);
    return region_e'(adr[`STILE_REGION_LSB +: `STILE_REGION_W]);
  endfunction

  function automatic tile_idx_t tile_of(input wb_adr_t adr);
    return adr[`STILE_TILE_LSB +: `STILE_TILE_W];
  endfunction

endpackage

/* stile_buffer.sv */
// Synchronous buffer memory
`timescale 1ns/10ps
`include "stile_config.svh"

module stile_buffer #(
  parameter type T     = logic,
  parameter int  DEPTH = `STILE_DEPTH
) (
  input  logic                       clk_h,
  input  logic                       rst_n,
  input  logic                       we,     // One write per cycle
  input  stile_types_pkg::buf_addr_t waddr,
  input  T                           wdata,
  input  stile_types_pkg::buf_addr_t raddr,
  output T                           rdata   // Valid one cycle after raddr
);

  T mem [DEPTH];

  // Write port
  always_ff @(posedge clk_h) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Read port with output register
  always_ff @(posedge clk_h or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else begin
      rdata <= mem[raddr];  // Same-address write shows next cycle
    end
  end

  // Loader or collector must never address past the array
  a_waddr_range: assert property (@(posedge clk_h) disable iff (!rst_n)
    we |-> (int'(waddr) < DEPTH))
    else $error("buffer write address %0d outside depth %0d", waddr, DEPTH);

endmodule

/* stile_loader.sv */
// Bus slave and run sequencer
`timescale 1ns/10ps
`include "stile_config.svh"

module stile_loader (
  input  logic                         clk_h,
  input  logic                         rst_n,
  input  logic                         cyc,
  input  logic                         stb,
  input  logic                         we,
  input  stile_bus_pkg::wb_adr_t       adr,
  input  logic [`STILE_WB_DATA_W-1:0]  dat_w,
  input  logic                         run_done,     // Last result written
  input  stile_types_pkg::psum_t       res_rd_data,
  output logic [`STILE_WB_DATA_W-1:0]  dat_r,
  output logic                         ack,
  output logic [`STILE_TILES-1:0]      weight_we,    // One-hot tile write
  output logic [`STILE_TILES-1:0]      act_we,
  output stile_types_pkg::buf_addr_t   wr_addr,
  output stile_types_pkg::weight_t     wr_weight,
  output stile_types_pkg::act_t        wr_act,
  output stile_types_pkg::buf_addr_t   rd_addr,      // Issue address to all tiles
  output logic                         issue_valid,
  output logic                         issue_last,
  output stile_types_pkg::psum_t       bias_psum,    // Head of the cascade
  output stile_types_pkg::buf_addr_t   res_rd_addr
);

  logic [`STILE_ACK_DELAY-1:0]  ack_sr;      // Strobe travels toward ack
  logic                         fire;        // Cycle before ack when the access acts
  logic                         wr_ok;       // Write taken while not busy
  logic                         ctrl_wr;
  logic                         start_wr;
  stile_bus_pkg::region_e       region;
  stile_bus_pkg::tile_idx_t     tile;
  stile_types_pkg::buf_addr_t   entry;
  logic                         busy;
  logic                         start_pend;  // First issue follows the start ack
  logic [`STILE_ADDR_W:0]       len_cnt;     // Addresses still to issue
  logic [`STILE_WB_DATA_W-1:0]  rd_mux;

  // Address fields
  assign region = stile_bus_pkg::region_of(adr);
  assign tile   = stile_bus_pkg::tile_of(adr);
  assign entry  = adr[`STILE_ADDR_W-1:0];

  // Ack shift takes a new request only once the previous one has left
  always_ff @(posedge clk_h or negedge rst_n) begin
    if (!rst_n) begin
      ack_sr <= '0;
    end else begin
      ack_sr <= {ack_sr[`STILE_ACK_DELAY-2:0], cyc & stb & ~(|ack_sr)};
    end
  end

  assign ack  = ack_sr[`STILE_ACK_DELAY-1];  // One-cycle pulse
  assign fire = ack_sr[`STILE_ACK_DELAY-2];

  // Write decode drops all writes during a run
  assign wr_ok    = fire & we & ~busy;
  assign ctrl_wr  = wr_ok && (region == stile_bus_pkg::REGION_CTRL);
  assign start_wr = ctrl_wr && (entry == stile_bus_pkg::CTRL_START);

  assign weight_we = (wr_ok && region == stile_bus_pkg::REGION_WEIGHT) ?
                     (`STILE_TILES'(1) << tile) : '0;
  assign act_we    = (wr_ok && region == stile_bus_pkg::REGION_ACT) ?
                     (`STILE_TILES'(1) << tile) : '0;

  assign wr_addr     = entry;
  assign wr_weight   = stile_types_pkg::weight_t'(dat_w[`STILE_WEIGHT_W-1:0]);
  assign wr_act      = dat_w[`STILE_ACT_W-1:0];
  assign res_rd_addr = entry;  // Result read lands in time for fire

  // Control registers and issue sequencer
  always_ff @(posedge clk_h or negedge rst_n) begin
    if (!rst_n) begin
      bias_psum   <= '0;
      busy        <= 1'b0;
      start_pend  <= 1'b0;
      len_cnt     <= '0;
      issue_valid <= 1'b0;
      issue_last  <= 1'b0;
      rd_addr     <= '0;
    end else begin
      if (ctrl_wr && entry == stile_bus_pkg::CTRL_BIAS) begin
        bias_psum <= dat_w;
      end
      start_pend <= start_wr;
      if (start_wr) begin
        busy    <= 1'b1;                   // Rises with the start ack
        len_cnt <= dat_w[`STILE_ADDR_W:0];
      end else if (run_done) begin
        busy    <= 1'b0;
      end
      if (start_pend || (issue_valid && !issue_last)) begin
        issue_valid <= 1'b1;
        issue_last  <= (len_cnt == (`STILE_ADDR_W+1)'(1));
        len_cnt     <= len_cnt - 1'b1;
        rd_addr     <= start_pend ? '0 : rd_addr + 1'b1;
      end else begin
        issue_valid <= 1'b0;
        issue_last  <= 1'b0;
      end
    end
  end

  // Read data select
  always_comb begin
    rd_mux = '0;  // Weight and act regions read zero
    case (region)
      stile_bus_pkg::REGION_CTRL: begin
        if (entry == stile_bus_pkg::CTRL_BIAS) begin
          rd_mux = bias_psum;
        end else if (entry == stile_bus_pkg::CTRL_STATUS) begin
          rd_mux[stile_bus_pkg::STATUS_BUSY_BIT] = busy;
        end
      end
      stile_bus_pkg::REGION_RESULT: rd_mux = res_rd_data;
      default: rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_h or negedge rst_n) begin
    if (!rst_n) begin
      dat_r <= '0;
    end else if (fire && !we) begin
      dat_r <= rd_mux;  // Held while ack is high
    end
  end

  // Ack only answers a strobe still held on the edge that raised it
  a_ack_needs_stb: assert property (@(posedge clk_h) disable iff (!rst_n)
    $rose(ack) |-> $past(cyc & stb))
    else $error("ack raised without strobe");

  // Issue only inside a run
  a_issue_in_run: assert property (@(posedge clk_h) disable iff (!rst_n)
    $rose(issue_valid) |-> busy)
    else $error("issue started while idle");

endmodule

/* stile_pe.sv */
// Convolution tile
`timescale 1ns/10ps
`include "stile_config.svh"

module stile_pe #(
  parameter int STAGE = 0  // Tile index in the chain
) (
  input  logic                       clk_h,
  input  logic                       rst_n,
  input  logic                       weight_we,
  input  logic                       act_we,
  input  stile_types_pkg::buf_addr_t wr_addr,
  input  stile_types_pkg::weight_t   wr_weight,
  input  stile_types_pkg::act_t      wr_act,
  input  stile_types_pkg::buf_addr_t rd_addr,   // Issue address
  input  logic                       in_valid,  // Issue aligned
  input  logic                       in_last,
  input  stile_types_pkg::psum_t     psum_in,   // Arrives STAGE+1 after issue
  output logic                       out_valid,
  output logic                       out_last,
  output stile_types_pkg::buf_addr_t out_addr,
  output stile_types_pkg::psum_t     psum_out   // STAGE+2 after issue
);

  stile_types_pkg::weight_t   w_rd, w_al;    // Buffer out, aligned
  stile_types_pkg::act_t      a_rd, a_al;
  logic                       v_rd, v_al;
  logic                       l_rd, l_al;
  stile_types_pkg::buf_addr_t ad_rd, ad_al;
  stile_types_pkg::psum_t     product;

  stile_buffer #(.T(stile_types_pkg::weight_t), .DEPTH(`STILE_DEPTH)) u_wbuf (
    .clk_h, .rst_n,
    .we(weight_we), .waddr(wr_addr), .wdata(wr_weight),
    .raddr(rd_addr), .rdata(w_rd)
  );

  stile_buffer #(.T(stile_types_pkg::act_t), .DEPTH(`STILE_DEPTH)) u_abuf (
    .clk_h, .rst_n,
    .we(act_we), .waddr(wr_addr), .wdata(wr_act),
    .raddr(rd_addr), .rdata(a_rd)
  );

  // Controls follow the buffer read latency
  always_ff @(posedge clk_h or negedge rst_n) begin
    if (!rst_n) begin
      v_rd <= 1'b0;
      l_rd <= 1'b0;
    end else begin
      v_rd <= in_valid;
      l_rd <= in_last;
    end
  end

  always_ff @(posedge clk_h) begin
    ad_rd <= rd_addr;
  end

  // STAGE-deep alignment so operands meet the cascade
  generate
    if (STAGE == 0) begin : g_no_align
      assign w_al  = w_rd;
      assign a_al  = a_rd;
      assign v_al  = v_rd;
      assign l_al  = l_rd;
      assign ad_al = ad_rd;
    end else begin : g_align
      stile_types_pkg::weight_t   w_sr  [STAGE];
      stile_types_pkg::act_t      a_sr  [STAGE];
      stile_types_pkg::buf_addr_t ad_sr [STAGE];
      logic                       v_sr  [STAGE];
      logic                       l_sr  [STAGE];

      always_ff @(posedge clk_h or negedge rst_n) begin
        if (!rst_n) begin
          v_sr <= '{default: 1'b0};
          l_sr <= '{default: 1'b0};
        end else begin
          v_sr[0] <= v_rd;
          l_sr[0] <= l_rd;
          for (int k = 1; k < STAGE; k++) begin
            v_sr[k] <= v_sr[k-1];
            l_sr[k] <= l_sr[k-1];
          end
        end
      end

      always_ff @(posedge clk_h) begin
        w_sr[0]  <= w_rd;
        a_sr[0]  <= a_rd;
        ad_sr[0] <= ad_rd;
        for (int k = 1; k < STAGE; k++) begin
          w_sr[k]  <= w_sr[k-1];
          a_sr[k]  <= a_sr[k-1];
          ad_sr[k] <= ad_sr[k-1];
        end
      end

      assign w_al  = w_sr[STAGE-1];
      assign a_al  = a_sr[STAGE-1];
      assign v_al  = v_sr[STAGE-1];
      assign l_al  = l_sr[STAGE-1];
      assign ad_al = ad_sr[STAGE-1];
    end
  endgenerate

  // Signed weight times zero-extended activation
  assign product = stile_types_pkg::psum_t'(w_al) * stile_types_pkg::psum_t'(a_al);

  // MAC register
  always_ff @(posedge clk_h or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      out_valid <= v_al;
      out_last  <= l_al;
    end
  end

  always_ff @(posedge clk_h) begin
    out_addr <= ad_al;
    psum_out <= psum_in + product;  // Wraps at 32 bits
  end

endmodule

/* stile_collector.sv */
// Result collector
`timescale 1ns/10ps
`include "stile_config.svh"

module stile_collector (
  input  logic                       clk_h,
  input  logic                       rst_n,
  input  logic                       in_valid,     // From the last tile
  input  logic                       in_last,
  input  stile_types_pkg::buf_addr_t in_addr,
  input  stile_types_pkg::psum_t     psum_in,
  input  stile_types_pkg::buf_addr_t res_rd_addr,  // Bus read side
  output stile_types_pkg::psum_t     res_rd_data,
  output logic                       run_done      // One-cycle pulse
);

  logic                       wr_en;
  stile_types_pkg::buf_addr_t wr_addr;
  stile_types_pkg::psum_t     wr_data;

  // Input stage, write lands one cycle later
  always_ff @(posedge clk_h or negedge rst_n) begin
    if (!rst_n) begin
      wr_en    <= 1'b0;
      run_done <= 1'b0;
    end else begin
      wr_en    <= in_valid;
      run_done <= in_valid & in_last;  // Same cycle as the final write
    end
  end

  always_ff @(posedge clk_h) begin
    wr_addr <= in_addr;
    wr_data <= psum_in;
  end

  stile_buffer #(.T(stile_types_pkg::psum_t), .DEPTH(`STILE_DEPTH)) u_result (
    .clk_h,
    .rst_n,
    .we    (wr_en),
    .waddr (wr_addr),
    .wdata (wr_data),
    .raddr (res_rd_addr),
    .rdata (res_rd_data)
  );

  // Last marker has to ride with a valid entry through every tile
  a_last_has_valid: assert property (@(posedge clk_h) disable iff (!rst_n)
    in_last |-> in_valid)
    else $error("last marker arrived without valid");

endmodule

/* stile_top.sv */
// Convolution super-tile
`timescale 1ns/10ps
`include "stile_config.svh"

module stile_top (
  input  logic                        clk_h,
  input  logic                        rst_n,
  input  logic                        cyc,
  input  logic                        stb,
  input  logic                        we,
  input  stile_bus_pkg::wb_adr_t      adr,
  input  logic [`STILE_WB_DATA_W-1:0] dat_w,
  output logic [`STILE_WB_DATA_W-1:0] dat_r,
  output logic                        ack
);

  logic [`STILE_TILES-1:0]    weight_we;
  logic [`STILE_TILES-1:0]    act_we;
  stile_types_pkg::buf_addr_t wr_addr;
  stile_types_pkg::weight_t   wr_weight;
  stile_types_pkg::act_t      wr_act;
  stile_types_pkg::buf_addr_t rd_addr;
  logic                       issue_valid;
  logic                       issue_last;
  stile_types_pkg::buf_addr_t res_rd_addr;
  stile_types_pkg::psum_t     res_rd_data;
  logic                       run_done;

  stile_types_pkg::psum_t     tile_psum [`STILE_TILES+1];  // [0] is the bias
  logic [`STILE_TILES-1:0]    tile_valid;
  logic [`STILE_TILES-1:0]    tile_last;
  stile_types_pkg::buf_addr_t tile_addr [`STILE_TILES];

  stile_loader u_loader (
    .clk_h, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
    .run_done, .res_rd_data, .weight_we, .act_we, .wr_addr, .wr_weight, .wr_act,
    .rd_addr, .issue_valid, .issue_last, .res_rd_addr,
    .bias_psum (tile_psum[0])
  );

  // Issue controls fan out, each tile aligns them to its own stage
  for (genvar i = 0; i < `STILE_TILES; i++) begin : g_tile
    stile_pe #(.STAGE(i)) u_pe (
      .clk_h, .rst_n, .wr_addr, .wr_weight, .wr_act, .rd_addr,
      .weight_we (weight_we[i]),
      .act_we    (act_we[i]),
      .in_valid  (issue_valid),
      .in_last   (issue_last),
      .psum_in   (tile_psum[i]),
      .out_valid (tile_valid[i]),
      .out_last  (tile_last[i]),
      .out_addr  (tile_addr[i]),
      .psum_out  (tile_psum[i+1])
    );
  end

  stile_collector u_collector (
    .clk_h, .rst_n, .res_rd_addr, .res_rd_data, .run_done,
    .in_valid (tile_valid[`STILE_TILES-1]),
    .in_last  (tile_last[`STILE_TILES-1]),
    .in_addr  (tile_addr[`STILE_TILES-1]),
    .psum_in  (tile_psum[`STILE_TILES])
  );

endmodule

/* tb_stile_checker.sv */
// Wishbone response checker
`timescale 1ns/10ps
`include "stile_config.svh"

module tb_stile_checker (
  input  logic                        clk_h,
  input  logic                        rst_n,
  input  logic                        cyc,
  input  logic                        stb,
  input  logic                        we,
  input  stile_bus_pkg::wb_adr_t      adr,
  input  logic [`STILE_WB_DATA_W-1:0] dat_r,
  input  logic                        ack,
  input  logic                        polling,
  output int                          mismatch_cnt,
  output int                          protocol_cnt,
  output int                          expects_left
);

  logic [7:0]             w_mod [`STILE_TILES][`STILE_DEPTH];  // What the tiles should hold
  logic [7:0]             a_mod [`STILE_TILES][`STILE_DEPTH];
  logic [31:0]            bias_mod = '0;
  logic                   run_f = 1'b0;  // Writes are dropped inside a run
  logic [31:0]            exp_q [$];     // Expected reads in bus order
  logic [31:0]            exp_val;
  int                     n_mismatch = 0;
  int                     n_protocol = 0;
  int                     n_left = 0;
  logic                   pending = 1'b0;
  int                     edges = 0;     // Rising edges since strobe seen
  logic                   acc_we;
  logic                   acc_poll;
  stile_bus_pkg::wb_adr_t acc_adr;

  assign mismatch_cnt = n_mismatch;
  assign protocol_cnt = n_protocol;
  assign expects_left = n_left;

  function automatic logic [7:0] fill_byte(input logic [7:0] seed, input int entry);
    return seed + 8'(entry * 29);
  endfunction

  task automatic model_write(input logic [9:0] a, input logic [31:0] d);
    stile_bus_pkg::region_e rg;
    int                     t;
    int                     e;
    rg = stile_bus_pkg::region_e'(a[`STILE_REGION_LSB +: `STILE_REGION_W]);
    t  = a[`STILE_TILE_LSB +: `STILE_TILE_W];
    e  = a[`STILE_ADDR_W-1:0];
    if (run_f) return;
    case (rg)
      stile_bus_pkg::REGION_WEIGHT: w_mod[t][e] = d[7:0];
      stile_bus_pkg::REGION_ACT:    a_mod[t][e] = d[7:0];
      stile_bus_pkg::REGION_CTRL: begin
        if (e == stile_bus_pkg::CTRL_BIAS) bias_mod = d;
        else if (e == stile_bus_pkg::CTRL_START) run_f = 1'b1;
      end
      default: ;
    endcase
  endtask

  // Bias plus signed weight times unsigned activation summed over tiles in 32 bits
  function automatic logic [31:0] result_of(input int e);
    int acc;
    acc = int'(bias_mod);
    for (int t = 0; t < `STILE_TILES; t++) begin
      acc += int'($signed(w_mod[t][e])) * int'(a_mod[t][e]);
    end
    return acc;
  endfunction

  // Replay the pattern file into a list of expected reads
  initial begin
    int          fd;
    string       line;
    logic [31:0] op, a, d;
    fd = $fopen("stile_patterns.txt", "r");
    if (fd == 0) begin
      $display("Checker could not open the pattern file stile_patterns.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%h %h %h", op, a, d) == 3) begin
          case (op)
            0: model_write(a[9:0], d);
            1: exp_q.push_back(d);
            2: run_f = 1'b0;  // Poll returns once idle
            3: begin
              for (int e = 0; e < `STILE_DEPTH; e++) begin
                model_write(a[9:0] | 10'(e), fill_byte(d[7:0], e));
              end
            end
            4: for (int e = 0; e < int'(d); e++) exp_q.push_back(result_of(e));
            default: ;
          endcase
        end
      end
      $fclose(fd);
    end
  end

  // Sample on the falling edge away from DUT updates
  always @(negedge clk_h) begin
    if (!rst_n) begin
      pending = 1'b0;
      edges   = 0;
    end else begin
      if (pending) edges++;
      if (ack) begin
        if (!pending) begin
          n_protocol++;
          $display("At %0t ack was high with no access waiting, not a one-cycle pulse", $time);
        end else if (edges != `STILE_ACK_DELAY) begin
          n_protocol++;
          $display("At %0t ack came %0d edges after strobe instead of %0d",
                   $time, edges, `STILE_ACK_DELAY);
        end else if (!acc_we && !acc_poll) begin
          if (exp_q.size() == 0) begin
            n_mismatch++;
            $display("mismatch at %0t: read of 0x%03h has no expected value left",
                     $time, acc_adr);
          end else begin
            exp_val = exp_q.pop_front();
            if (dat_r !== exp_val) begin
              n_mismatch++;
              $display("mismatch at %0t: read of 0x%03h gave 0x%08h, expected 0x%08h",
                       $time, acc_adr, dat_r, exp_val);
            end
          end
        end
        pending = 1'b0;
      end else if (pending && edges >= `STILE_ACK_DELAY) begin
        n_protocol++;
        $display("At %0t no ack on edge %0d after strobe to 0x%03h", $time, edges, acc_adr);
        pending = 1'b0;
      end
      if (!pending && !ack && cyc && stb) begin  // New access is first sampled on the next edge
        pending  = 1'b1;
        edges    = 0;
        acc_we   = we;
        acc_poll = polling;
        acc_adr  = adr;
      end
    end
    n_left = exp_q.size();
  end

endmodule

/* tb_stile.sv */
// Super-tile testbench
`timescale 1ns/10ps
`include "stile_config.svh"

module tb_stile;

  localparam int MAX_POLLS = 64;  // Status reads before a run counts as stuck

  logic                        clk_h;
  logic                        rst_n;
  logic                        cyc;
  logic                        stb;
  logic                        we;
  stile_bus_pkg::wb_adr_t      adr;
  logic [`STILE_WB_DATA_W-1:0] dat_w;
  logic [`STILE_WB_DATA_W-1:0] dat_r;
  logic                        ack;
  logic                        polling;  // Status reads the checker leaves alone

  logic [31:0] op_q  [$];  // Pattern file columns
  logic [31:0] adr_q [$];
  logic [31:0] dat_q [$];
  logic [31:0] lcg_state = 32'd15294;
  int          wd_cycles = 0;
  int          tb_errors = 0;
  int          mismatch_cnt;
  int          protocol_cnt;
  int          expects_left;
  int          total;

  stile_top UUT (.clk_h, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack);

  tb_stile_checker u_checker (
    .clk_h, .rst_n, .cyc, .stb, .we, .adr, .dat_r, .ack, .polling,
    .mismatch_cnt, .protocol_cnt, .expects_left
  );

  initial begin
    clk_h = 1'b0;
    forever #2 clk_h = ~clk_h;  // 4 ns period
  end

  // Idle cycles between accesses, 0 to 3
  function automatic int idle_gap();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[17:16]);
  endfunction

  // Fill data, odd step so every entry bit moves the value
  function automatic logic [7:0] fill_byte(input logic [7:0] seed, input int entry);
    return seed + 8'(entry * 29);
  endfunction

  task automatic load_ops();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_op, f_adr, f_dat;
    fd = $fopen("stile_patterns.txt", "r");
    if (fd == 0) begin
      tb_errors++;
      $display("Could not open the pattern file stile_patterns.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%h %h %h", f_op, f_adr, f_dat);
      if (n == 3) begin  // Comment and blank lines fall out here
        op_q.push_back(f_op);
        adr_q.push_back(f_adr);
        dat_q.push_back(f_dat);
      end
    end
    $fclose(fd);
  endtask

  // Worst case about 12 cycles per access
  function automatic int watchdog_cycles();
    int acc;
    acc = 0;
    foreach (op_q[i]) begin
      case (op_q[i])
        2:       acc += MAX_POLLS;
        3:       acc += `STILE_DEPTH;
        4:       acc += int'(dat_q[i]);
        default: acc += 1;
      endcase
    end
    return acc * 12 + 200;
  endfunction

  // One Wishbone classic cycle, held until ack
  task automatic bus_access(input logic wr, input stile_bus_pkg::wb_adr_t a,
                            input logic [31:0] d, output logic [31:0] q);
    int waited;
    repeat (idle_gap() + 1) @(posedge clk_h);
    #1;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = wr;
    adr   = a;
    dat_w = d;
    waited = 0;
    do begin
      @(posedge clk_h);
      #1;  // ack and dat_r settled
      waited++;
    end while (!ack && waited < 8);
    if (!ack) begin
      tb_errors++;
      $display("No ack for access to 0x%03h within 8 cycles", a);
    end
    q   = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic run_op(input logic [31:0] op, input logic [31:0] a, input logic [31:0] d);
    logic [31:0]            q;
    int                     tries;
    stile_bus_pkg::wb_adr_t ra;
    case (op)
      0: bus_access(1'b1, a[9:0], d, q);
      1: bus_access(1'b0, a[9:0], '0, q);
      2: begin
        polling = 1'b1;
        tries   = 0;
        q       = 32'd1;
        while (q[stile_bus_pkg::STATUS_BUSY_BIT] && tries < MAX_POLLS) begin
          bus_access(1'b0, a[9:0], '0, q);
          tries++;
        end
        polling = 1'b0;
        if (q[stile_bus_pkg::STATUS_BUSY_BIT]) begin
          tb_errors++;
          $display("Status still busy after %0d polls", tries);
        end
      end
      3: for (int e = 0; e < `STILE_DEPTH; e++) begin
        bus_access(1'b1, a[9:0] | 10'(e), {24'd0, fill_byte(d[7:0], e)}, q);
      end
      4: for (int e = 0; e < int'(d); e++) begin
        ra = 10'(e);
        ra[`STILE_REGION_LSB +: `STILE_REGION_W] = stile_bus_pkg::REGION_RESULT;
        bus_access(1'b0, ra, '0, q);  // Checker holds the expected value
      end
      default: begin
        tb_errors++;
        $display("Unknown operation %0d in the pattern file", op);
      end
    endcase
  endtask

  initial begin
    cyc     = 1'b0;
    stb     = 1'b0;
    we      = 1'b0;
    adr     = '0;
    dat_w   = '0;
    polling = 1'b0;
    rst_n   = 1'b0;
    load_ops();
    wd_cycles = watchdog_cycles();
    repeat (8) @(posedge clk_h);
    #1 rst_n = 1'b1;
    foreach (op_q[i]) begin
      run_op(op_q[i], adr_q[i], dat_q[i]);
    end
    repeat (4) @(posedge clk_h);  // Last ack reaches the checker
    total = tb_errors + mismatch_cnt + protocol_cnt + expects_left;
    $display("Errors: %0d mismatch, %0d bus protocol, %0d testbench, %0d reads never seen",
             mismatch_cnt, protocol_cnt, tb_errors, expects_left);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk_h);
    $display("Run timed out after %0d cycles", wd_cycles);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* stile_patterns.txt */
# op adr data, all hex. op 0 write, 1 read and expect data, 2 poll status until idle,
# 3 fill 64 entries from base adr with seed data, 4 read results 0 to data-1 against the model
1 202 00000000
1 005 00000000
3 000 11
3 040 C3
3 080 7A
3 0C0 E5
3 100 05
3 140 A0
3 180 3C
3 1C0 F1
0 000 00000080
0 100 000000FF
0 201 FFFFFF9C
1 201 FFFFFF9C
0 200 00000008
1 202 00000001
0 201 00000005
2 202 0
1 201 FFFFFF9C
1 202 00000000
4 000 8
1 300 FFFF5D29
0 200 00000008
0 000 00000001
0 100 00000000
2 202 0
4 000 8
1 300 FFFF5D29
3 080 9D
0 200 00000040
2 202 0
4 000 40
1 202 00000000

/* compile.f */
+incdir+.
stile_types_pkg.sv
stile_bus_pkg.sv
stile_buffer.sv
stile_loader.sv
stile_pe.sv
stile_collector.sv
stile_top.sv
tb_stile_checker.sv
tb_stile.sv
